// File: common/vred_defs.svh
// Vector reduction unit sizing
// Vector length, element widths and tree depth

`ifndef VRED_DEFS_SVH
`define VRED_DEFS_SVH

`define VRED_VLEN       128 // Vector register width in bits
`define VRED_MIN_SEW    8   // Narrowest element
`define VRED_XLEN       64  // Scalar seed and the widest element

// log2(VLEN / MIN_SEW) halving stages reduce the narrowest elements to one
`define VRED_NUM_STAGES 4

`endif

// File: common/vred_pkg.sv
// Vector reduction unit types
// Width typedefs and the element width and operation encodings

`include "vred_defs.svh"

package vred_pkg;

    // One full vector register operand
    typedef logic [`VRED_VLEN-1:0] vreg_t;

    // Bit k is the mask of element k at the current SEW
    typedef logic [`VRED_VLEN/`VRED_MIN_SEW-1:0] vmask_t;

    // Scalar seed and the widest element
    typedef logic [`VRED_XLEN-1:0] scalar_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_e;

    typedef enum logic [1:0] {
        RED_SUM = 2'b00,
        RED_AND = 2'b01,
        RED_OR  = 2'b10,
        RED_XOR = 2'b11
    } red_op_e;

endpackage

// File: vred_tree/vred_pair_combine.sv
// Reduction tree pair combiner
// Merges two neighbouring elements under their mask bits and the operation

`timescale 1ns/1ps
`include "vred_defs.svh"

module vred_pair_combine (
    input  vred_pkg::scalar_t elem_a_i,
    input  vred_pkg::scalar_t elem_b_i,
    input  logic              mask_a_i,
    input  logic              mask_b_i,
    input  vred_pkg::red_op_e op_i,
    input  vred_pkg::sew_e    sew_i,
    output vred_pkg::scalar_t elem_o,
    output logic              mask_o
);

    logic [6:0]        sew_bits;
    vred_pkg::scalar_t sew_mask;
    vred_pkg::scalar_t op_res;
    vred_pkg::scalar_t pair_res;

    assign sew_bits = 7'(`VRED_MIN_SEW) << sew_i;
    assign sew_mask = {`VRED_XLEN{1'b1}} >> (7'(`VRED_XLEN) - sew_bits);

    always_comb begin
        case (op_i)
            vred_pkg::RED_SUM: op_res = elem_a_i + elem_b_i; // Carry out of SEW cut below
            vred_pkg::RED_AND: op_res = elem_a_i & elem_b_i;
            vred_pkg::RED_OR:  op_res = elem_a_i | elem_b_i;
            default:           op_res = elem_a_i ^ elem_b_i;
        endcase
    end

    always_comb begin
        case ({mask_b_i, mask_a_i})
            2'b00:   pair_res = '0;       // Both inactive
            2'b01:   pair_res = elem_a_i;
            2'b10:   pair_res = elem_b_i;
            default: pair_res = op_res;
        endcase
    end

    // Upper bits of the inputs may hold neighbour data, the mask drops them
    assign elem_o = pair_res & sew_mask;
    assign mask_o = mask_a_i | mask_b_i;

endmodule

// File: vred_tree/vred_tree_stage.sv
// Reduction tree halving stage
// Pairs neighbouring elements at the current SEW and registers the
// half-length vector, its mask and the sideband fields

`timescale 1ns/1ps
`include "vred_defs.svh"

module vred_tree_stage (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              valid_i,
    input  vred_pkg::sew_e    sew_i,
    input  vred_pkg::red_op_e op_i,
    input  vred_pkg::vreg_t   vec_i,
    input  vred_pkg::vmask_t  mask_i,
    input  vred_pkg::scalar_t seed_i,
    output logic              valid_o,
    output vred_pkg::sew_e    sew_o,
    output vred_pkg::red_op_e op_o,
    output vred_pkg::vreg_t   vec_o,
    output vred_pkg::vmask_t  mask_o,
    output vred_pkg::scalar_t seed_o
);

    localparam int NUM_PAIRS = `VRED_VLEN / (2 * `VRED_MIN_SEW);

    logic [9:0]           sew_bits;
    vred_pkg::scalar_t    pair_elem [NUM_PAIRS];
    logic [NUM_PAIRS-1:0] pair_mask;
    vred_pkg::vreg_t      vec_d;
    vred_pkg::vmask_t     mask_d;

    assign sew_bits = 10'(`VRED_MIN_SEW) << sew_i;

    for (genvar j = 0; j < NUM_PAIRS; j++) begin : g_pair
        logic [9:0]        shift_a;
        logic [9:0]        shift_b;
        logic              in_range;
        vred_pkg::scalar_t elem_a;
        vred_pkg::scalar_t elem_b;

        assign shift_a  = sew_bits * 10'(2 * j);
        assign shift_b  = shift_a + sew_bits;
        assign in_range = shift_b < 10'(`VRED_VLEN); // Pair lies inside the register

        // Shifting past VLEN leaves zero
        assign elem_a = vred_pkg::scalar_t'(vec_i >> shift_a);
        assign elem_b = vred_pkg::scalar_t'(vec_i >> shift_b);

        vred_pair_combine u_pair (
            .elem_a_i (elem_a),
            .elem_b_i (elem_b),
            .mask_a_i (mask_i[2*j] & in_range),
            .mask_b_i (mask_i[2*j+1] & in_range),
            .op_i     (op_i),
            .sew_i    (sew_i),
            .elem_o   (pair_elem[j]),
            .mask_o   (pair_mask[j])
        );
    end

    // Repack the results as elements 0..NUM_PAIRS-1, upper half stays zero
    always_comb begin
        vec_d  = '0;
        mask_d = '0;
        for (int j = 0; j < NUM_PAIRS; j++) begin
            vec_d     = vec_d | (vred_pkg::vreg_t'(pair_elem[j]) << (sew_bits * 10'(j)));
            mask_d[j] = pair_mask[j];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
            sew_o   <= vred_pkg::SEW_8;
            op_o    <= vred_pkg::RED_SUM;
            vec_o   <= '0;
            mask_o  <= '0;
            seed_o  <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                sew_o  <= sew_i;
                op_o   <= op_i;
                vec_o  <= vec_d;
                mask_o <= mask_d;
                seed_o <= seed_i;
            end
        end
    end

endmodule

// File: source/vred_seed_combine.sv
// Reduction seed stage
// Folds the last remaining element into the scalar seed and
// fills every result bit above SEW with ones

`timescale 1ns/1ps
`include "vred_defs.svh"

module vred_seed_combine (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              valid_i,
    input  vred_pkg::sew_e    sew_i,
    input  vred_pkg::red_op_e op_i,
    input  vred_pkg::vreg_t   vec_i,
    input  vred_pkg::vmask_t  mask_i,
    input  vred_pkg::scalar_t seed_i,
    output logic              valid_o,
    output vred_pkg::vreg_t   result_o
);

    logic [6:0]        sew_bits;
    vred_pkg::scalar_t sew_mask;
    vred_pkg::scalar_t elem0;
    vred_pkg::scalar_t op_res;
    vred_pkg::scalar_t fold;
    vred_pkg::vreg_t   result_d;

    assign sew_bits = 7'(`VRED_MIN_SEW) << sew_i;
    assign sew_mask = {`VRED_XLEN{1'b1}} >> (7'(`VRED_XLEN) - sew_bits);
    assign elem0    = vec_i[`VRED_XLEN-1:0];

    always_comb begin
        case (op_i)
            vred_pkg::RED_SUM: op_res = elem0 + seed_i;
            vred_pkg::RED_AND: op_res = elem0 & seed_i;
            vred_pkg::RED_OR:  op_res = elem0 | seed_i;
            default:           op_res = elem0 ^ seed_i;
        endcase
    end

    // No active element leaves the seed untouched
    assign fold     = mask_i[0] ? op_res : seed_i;
    assign result_d = {{(`VRED_VLEN-`VRED_XLEN){1'b1}}, fold | ~sew_mask}; // Tail-agnostic ones

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o <= result_d;
            end
        end
    end

endmodule

// File: source/vred_top.sv
// Pipelined vector reduction unit
// Halving tree stages followed by the seed stage, fixed five-cycle latency

`timescale 1ns/1ps
`include "vred_defs.svh"

module vred_top (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              valid_i,
    input  vred_pkg::sew_e    sew_i,
    input  vred_pkg::red_op_e op_i,
    input  vred_pkg::vreg_t   vec_i,
    input  vred_pkg::vmask_t  mask_i,
    input  vred_pkg::scalar_t seed_i,
    output logic              valid_o,
    output vred_pkg::vreg_t   result_o
);

    // Index k feeds tree stage k, the last index feeds the seed stage
    logic              valid_s [`VRED_NUM_STAGES+1];
    vred_pkg::sew_e    sew_s   [`VRED_NUM_STAGES+1];
    vred_pkg::red_op_e op_s    [`VRED_NUM_STAGES+1];
    vred_pkg::vreg_t   vec_s   [`VRED_NUM_STAGES+1];
    vred_pkg::vmask_t  mask_s  [`VRED_NUM_STAGES+1];
    vred_pkg::scalar_t seed_s  [`VRED_NUM_STAGES+1];

    assign valid_s[0] = valid_i;
    assign sew_s[0]   = sew_i;
    assign op_s[0]    = op_i;
    assign vec_s[0]   = vec_i;
    assign mask_s[0]  = mask_i;
    assign seed_s[0]  = seed_i;

    for (genvar k = 0; k < `VRED_NUM_STAGES; k++) begin : g_stage
        vred_tree_stage u_stage (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .valid_i (valid_s[k]),
            .sew_i   (sew_s[k]),
            .op_i    (op_s[k]),
            .vec_i   (vec_s[k]),
            .mask_i  (mask_s[k]),
            .seed_i  (seed_s[k]),
            .valid_o (valid_s[k+1]),
            .sew_o   (sew_s[k+1]),
            .op_o    (op_s[k+1]),
            .vec_o   (vec_s[k+1]),
            .mask_o  (mask_s[k+1]),
            .seed_o  (seed_s[k+1])
        );
    end

    vred_seed_combine u_seed (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .valid_i  (valid_s[`VRED_NUM_STAGES]),
        .sew_i    (sew_s[`VRED_NUM_STAGES]),
        .op_i     (op_s[`VRED_NUM_STAGES]),
        .vec_i    (vec_s[`VRED_NUM_STAGES]),
        .mask_i   (mask_s[`VRED_NUM_STAGES]),
        .seed_i   (seed_s[`VRED_NUM_STAGES]),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

endmodule

// File: dv/vred_asserts.sv
// Vector reduction unit output checks
// Reset behaviour, fixed latency and clean results on valid_o

`timescale 1ns/1ps
`include "vred_defs.svh"

module vred_asserts (
    input logic            clk_i,
    input logic            rstn_i,
    input logic            valid_i,
    input logic            valid_o,
    input vred_pkg::vreg_t result_o
);

    localparam int LATENCY = `VRED_NUM_STAGES + 1;

    int unsigned fail_count = 0; // Count of failed assertions

    a_idle_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !valid_o)
        else begin
            $error("valid_o is high while reset is asserted");
            fail_count++;
        end

    a_fixed_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o == $past(valid_i, LATENCY))
        else begin
            $error("valid_o does not follow valid_i by %0d cycles", LATENCY);
            fail_count++;
        end

    a_result_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> !$isunknown(result_o))
        else begin
            $error("result_o has unknown bits while valid_o is high");
            fail_count++;
        end

endmodule

bind vred_top vred_asserts u_asserts (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .valid_i  (valid_i),
    .valid_o  (valid_o),
    .result_o (result_o)
);

// File: dv/tb_vred_top.sv
// Testbench for the pipelined vector reduction unit
// Directed and random reductions checked against a reference model

`timescale 1ns/1ps
`include "vred_defs.svh"

module tb_vred_top;

    localparam int LATENCY = `VRED_NUM_STAGES + 1;

    logic              clk_i;
    logic              rstn_i;
    logic              valid_i;
    vred_pkg::sew_e    sew_i;
    vred_pkg::red_op_e op_i;
    vred_pkg::vreg_t   vec_i;
    vred_pkg::vmask_t  mask_i;
    vred_pkg::scalar_t seed_i;
    logic              valid_o;
    vred_pkg::vreg_t   result_o;

    vred_pkg::vreg_t exp_q [$];  // Expected results in issue order
    int              due_q [$];  // Cycle in which each result is due
    string           name_q [$];
    int              cycle_cnt;
    logic [31:0]     rng_state;
    string           test_name;

    vred_top u_dut (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .valid_i  (valid_i),
        .sew_i    (sew_i),
        .op_i     (op_i),
        .vec_i    (vec_i),
        .mask_i   (mask_i),
        .seed_i   (seed_i),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic vred_pkg::vreg_t random_vec();
        return {next_random(), next_random(), next_random(), next_random()};
    endfunction

    function automatic vred_pkg::scalar_t apply_op(vred_pkg::red_op_e op,
                                                    vred_pkg::scalar_t a,
                                                    vred_pkg::scalar_t b);
        case (op)
            vred_pkg::RED_SUM: return a + b;
            vred_pkg::RED_AND: return a & b;
            vred_pkg::RED_OR:  return a | b;
            default:           return a ^ b;
        endcase
    endfunction

    // Serial fold of the active elements, then the seed
    function automatic vred_pkg::vreg_t ref_reduce(vred_pkg::vreg_t   vec,
                                                   vred_pkg::vmask_t  mask,
                                                   vred_pkg::scalar_t seed,
                                                   vred_pkg::sew_e    sew,
                                                   vred_pkg::red_op_e op);
        int                width;
        vred_pkg::scalar_t low_mask;
        vred_pkg::scalar_t elem;
        vred_pkg::scalar_t acc;
        vred_pkg::scalar_t res;
        bit                any;
        width    = `VRED_MIN_SEW << int'(sew);
        low_mask = (width == 64) ? '1 : ((64'd1 << width) - 64'd1);
        acc      = '0;
        any      = 1'b0;
        for (int k = 0; k < `VRED_VLEN / width; k++) begin
            elem = vred_pkg::scalar_t'(vec >> (k * width)) & low_mask;
            if (mask[k]) begin
                acc = any ? apply_op(op, acc, elem) : elem;
                any = 1'b1;
            end
        end
        res = any ? apply_op(op, acc, seed) : seed;
        return {{(`VRED_VLEN-`VRED_XLEN){1'b1}}, (res & low_mask) | ~low_mask};
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input vred_pkg::vreg_t exp_val,
                               input vred_pkg::vreg_t act_val);
        if (exp_val !== act_val) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h",
                               name, exp_val, act_val));
        end
    endtask

    task automatic send_op(input vred_pkg::vreg_t vec, input vred_pkg::vmask_t mask,
                           input vred_pkg::scalar_t seed, input vred_pkg::sew_e sew,
                           input vred_pkg::red_op_e op, input vred_pkg::vreg_t expected);
        @(posedge clk_i);
        #1;
        valid_i = 1'b1;
        vec_i   = vec;
        mask_i  = mask;
        seed_i  = seed;
        sew_i   = sew;
        op_i    = op;
        exp_q.push_back(expected);
        due_q.push_back(cycle_cnt + LATENCY); // Sampled at the next edge
        name_q.push_back(test_name);
    endtask

    task automatic send_ref(input vred_pkg::vreg_t vec, input vred_pkg::vmask_t mask,
                            input vred_pkg::scalar_t seed, input vred_pkg::sew_e sew,
                            input vred_pkg::red_op_e op);
        send_op(vec, mask, seed, sew, op, ref_reduce(vec, mask, seed, sew, op));
    endtask

    task automatic go_idle();
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic wait_results(input int max_cycles);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            waited++;
            if (waited > max_cycles) begin
                fail_run($sformatf("Timeout in %s: results still pending after %0d cycles",
                                   test_name, max_cycles));
            end
        end
    endtask

    // Scoreboard samples on the falling edge
    always @(negedge clk_i) begin
        if (u_dut.u_asserts.fail_count != 0) begin
            fail_run("A concurrent assertion on the DUT outputs failed");
        end else if (rstn_i) begin
            if (valid_o) begin
                if (exp_q.size() == 0) begin
                    fail_run("A result appeared with no operation pending");
                end else begin
                    check_value({name_q[0], " latency"}, due_q[0], cycle_cnt);
                    check_value(name_q[0], exp_q[0], result_o);
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                    void'(name_q.pop_front());
                end
            end else if (due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
                fail_run($sformatf("No result for %s by its due cycle", name_q[0]));
            end
        end
    end

    initial begin : main
        vred_pkg::vmask_t  mask;
        vred_pkg::sew_e    sew;
        vred_pkg::red_op_e op;
        logic [31:0]       r;
        int                n;
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        valid_i   = 1'b0;
        sew_i     = vred_pkg::SEW_8;
        op_i      = vred_pkg::RED_SUM;
        vec_i     = '0;
        mask_i    = '0;
        seed_i    = '0;
        cycle_cnt = 0;
        rng_state = 32'd58989;
        test_name = "reset";
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        test_name = "all_active";
        send_op({16{8'h01}}, '1, '0, vred_pkg::SEW_8, vred_pkg::RED_SUM,
                {{120{1'b1}}, 8'h10});
        send_op({64'hFFFF0000_FFFF0000, 64'h00000000_FFFFFFFF}, '1, 64'h1,
                vred_pkg::SEW_64, vred_pkg::RED_XOR, {{64{1'b1}}, 64'hFFFF0000_0000FFFE});
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 4; o++) begin
                send_ref(random_vec(), '1, {next_random(), next_random()},
                         vred_pkg::sew_e'(s), vred_pkg::red_op_e'(o));
            end
        end
        go_idle();
        wait_results(20);

        test_name = "single_active";
        send_op({32'hAAAA_AAAA, 32'h0F0F_00FF, 32'h5555_5555, 32'h1234_5678}, 16'h0004,
                64'hFFFF_FFFF_F0F0_FF0F, vred_pkg::SEW_32, vred_pkg::RED_AND,
                {{96{1'b1}}, 32'h0000_000F});
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 4; o++) begin
                n       = `VRED_VLEN / (`VRED_MIN_SEW << s);
                r       = next_random();
                mask    = '0;
                mask[r % n] = 1'b1; // One element inside the register
                send_ref(random_vec(), mask, {next_random(), next_random()},
                         vred_pkg::sew_e'(s), vred_pkg::red_op_e'(o));
            end
        end
        go_idle();
        wait_results(20);

        test_name = "none_active";
        send_op(random_vec(), '0, 64'h1234_5678_9ABC_DEF0, vred_pkg::SEW_16,
                vred_pkg::RED_SUM, {{112{1'b1}}, 16'hDEF0});
        for (int s = 0; s < 4; s++) begin
            r = next_random();
            send_ref(random_vec(), '0, {next_random(), next_random()},
                     vred_pkg::sew_e'(s), vred_pkg::red_op_e'(r[1:0]));
        end
        go_idle();
        wait_results(20);

        test_name = "back_to_back";
        for (int i = 0; i < 200; i++) begin
            r    = next_random();
            sew  = vred_pkg::sew_e'(r[1:0]);
            op   = vred_pkg::red_op_e'(r[3:2]);
            mask = r[31:16];
            send_ref(random_vec(), mask, {next_random(), next_random()}, sew, op);
        end
        go_idle();
        wait_results(20);

        test_name = "reset_mid_stream";
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            send_ref(random_vec(), r[31:16], {next_random(), next_random()},
                     vred_pkg::sew_e'(r[1:0]), vred_pkg::red_op_e'(r[3:2]));
        end
        @(posedge clk_i);
        #1;
        check_value("reset_mid_stream valid_o before reset", 1, valid_o);
        rstn_i  = 1'b0;
        valid_i = 1'b0;
        exp_q.delete(); // In-flight operations are lost
        due_q.delete();
        name_q.delete();
        #1;
        check_value("reset_mid_stream valid_o in reset", 0, valid_o);
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        repeat (10) @(posedge clk_i);
        for (int i = 0; i < 5; i++) begin
            r = next_random();
            send_ref(random_vec(), r[31:16], {next_random(), next_random()},
                     vred_pkg::sew_e'(r[1:0]), vred_pkg::red_op_e'(r[3:2]));
        end
        go_idle();
        wait_results(20);

        if (u_dut.u_asserts.fail_count != 0) begin
            fail_run("Concurrent assertions on the DUT outputs failed");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: sim.f
+incdir+common
common/vred_pkg.sv
vred_tree/vred_pair_combine.sv
vred_tree/vred_tree_stage.sv
source/vred_seed_combine.sv
source/vred_top.sv
dv/vred_asserts.sv
dv/tb_vred_top.sv

// File: Bender.yml
package:
  name: vred

export_include_dirs:
  - common

sources:
  - common/vred_pkg.sv
  - vred_tree/vred_pair_combine.sv
  - vred_tree/vred_tree_stage.sv
  - source/vred_seed_combine.sv
  - source/vred_top.sv
  - target: test
    files:
      - dv/vred_asserts.sv
      - dv/tb_vred_top.sv
